// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_spi_wb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	test $$status -eq 0 && ! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/spi_wb_bridge.sv ====
`timescale 1ns/100ps

module spi_wb_bridge (
  input  logic                sys_clk,
  input  logic                reset_i,
  input  logic                cs_n_i,
  input  logic                sclk_i,
  input  logic                mosi_i,
  output logic                miso_o,
  output spi_wb_pkg::wb_req_t req_o,
  input  spi_wb_pkg::wb_rsp_t rsp_i,
  output logic                cmd_stb_o
);

  typedef enum logic [1:0] {IDLE, SHIFT_IN, BUS, SHIFT_OUT} state_t;

  state_t              state;
  logic [1:0]          cs_sync;
  logic [1:0]          sclk_sync;
  logic [1:0]          mosi_sync;
  logic                sclk_prev;
  logic                sclk_rise;
  logic                sclk_fall;
  logic                cs_n_s;
  logic                mosi_s;
  spi_wb_pkg::bitcnt_t bit_cnt;
  spi_wb_pkg::data_t   shift_in;
  spi_wb_pkg::data_t   rx_word;
  spi_wb_pkg::data_t   shift_out;
  spi_wb_pkg::opcode_t opcode_q;
  spi_wb_pkg::wb_req_t req_q;
  logic                cmd_stb_q;
  logic                miso_q;

  // ****************************************
  // Pin synchronizers and sclk edges
  // ****************************************
  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      cs_sync   <= 2'b11;
      sclk_sync <= 2'b00;
      sclk_prev <= 1'b0;
    end else begin
      cs_sync   <= {cs_sync[0], cs_n_i};
      sclk_sync <= {sclk_sync[0], sclk_i};
      sclk_prev <= sclk_sync[1];
    end
  end

  always_ff @(posedge sys_clk) begin
    mosi_sync <= {mosi_sync[0], mosi_i};
  end

  assign cs_n_s    = cs_sync[1];
  assign mosi_s    = mosi_sync[1];
  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;

  // The word as it stands once the current mosi bit is shifted in.
  assign rx_word = {shift_in[30:0], mosi_s};

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      bit_cnt <= '0;
    end else if (state == IDLE) begin
      bit_cnt <= '0;
    end else if (sclk_rise && bit_cnt != '1) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sclk_rise) begin
      shift_in <= rx_word;
      if (bit_cnt == spi_wb_pkg::OPC_LAST_BIT) begin
        opcode_q <= rx_word[7:0];
      end
    end
  end

  // ****************************************
  // Frame control and bus master
  // ****************************************
  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      state     <= IDLE;
      req_q.cyc <= 1'b0;
      req_q.stb <= 1'b0;
      req_q.we  <= 1'b0;
      cmd_stb_q <= 1'b0;
      miso_q    <= 1'b0;
    end else begin
      cmd_stb_q <= 1'b0;
      case (state)
        IDLE: begin
          miso_q <= 1'b0;
          if (!cs_n_s) begin
            state <= SHIFT_IN;
          end
        end
        SHIFT_IN: begin
          if (sclk_rise && bit_cnt == spi_wb_pkg::ADR_LAST_BIT) begin
            req_q.adr <= rx_word[15:0];
          end
          // A bit that arrives with cs_n rising still completes the frame.
          if (sclk_rise && opcode_q == spi_wb_pkg::OP_WRITE &&
              bit_cnt == spi_wb_pkg::WR_LAST_BIT) begin
            req_q.cyc <= 1'b1;
            req_q.stb <= 1'b1;
            req_q.we  <= 1'b1;
            req_q.dat <= rx_word;
            state     <= BUS;
          end else if (sclk_rise && opcode_q == spi_wb_pkg::OP_READ &&
                       bit_cnt == spi_wb_pkg::ADR_LAST_BIT) begin
            req_q.cyc <= 1'b1;
            req_q.stb <= 1'b1;
            req_q.we  <= 1'b0;
            state     <= BUS;
          end else if (cs_n_s) begin
            state <= IDLE;
          end
        end
        BUS: begin
          if (rsp_i.ack || rsp_i.err) begin
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
            cmd_stb_q <= 1'b1;
            shift_out <= rsp_i.err ? spi_wb_pkg::ERR_WORD : rsp_i.dat;
            state     <= req_q.we ? SHIFT_IN : SHIFT_OUT;
          end
        end
        SHIFT_OUT: begin
          if (cs_n_s) begin
            state <= IDLE;
          end else if (sclk_fall && bit_cnt >= spi_wb_pkg::RD_FIRST_BIT) begin
            miso_q    <= shift_out[31];
            shift_out <= {shift_out[30:0], 1'b0};
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign req_o     = req_q;
  assign cmd_stb_o = cmd_stb_q;
  assign miso_o    = miso_q;

endmodule

// ==== hdl/spi_wb_pkg.sv ====
package spi_wb_pkg;

  // ****************************************
  // Widths
  // ****************************************
  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [6:0]  bitcnt_t;

  localparam opcode_t OP_WRITE = 8'h01;
  localparam opcode_t OP_READ  = 8'h02;

  // Bit counter values seen on the rising sclk edge that carries the bit.
  localparam bitcnt_t OPC_LAST_BIT = 7'd7;
  localparam bitcnt_t ADR_LAST_BIT = 7'd23;
  localparam bitcnt_t WR_LAST_BIT  = 7'd55;
  localparam bitcnt_t RD_FIRST_BIT = 7'd32;

  // ****************************************
  // Address map
  // ****************************************
  localparam addr_t SYS_BASE = 16'h0000;
  localparam addr_t SYS_HIGH = 16'h00FF;
  localparam addr_t RAM_BASE = 16'h1000;
  localparam addr_t RAM_HIGH = 16'h10FF;

  localparam logic [7:0] REG_ID      = 8'h00;
  localparam logic [7:0] REG_REV     = 8'h04;
  localparam logic [7:0] REG_SCRATCH = 8'h08;
  localparam logic [7:0] REG_DEBUG   = 8'h0C;

  localparam data_t       BOARD_ID = 32'd12;
  localparam logic [15:0] REV_MAJ  = 16'd1;
  localparam logic [15:0] REV_MIN  = 16'd0;
  localparam data_t       ERR_WORD = 32'hBAD0_BAD0;

  localparam int RAM_WORDS = 64;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

endpackage

// ==== hdl/spi_wb_top.sv ====
`timescale 1ns/100ps

module spi_wb_top (
  input  logic              sys_clk,
  input  logic              reset_i,
  input  logic              cs_n_i,
  input  logic              sclk_i,
  input  logic              mosi_i,
  output logic              miso_o,
  output logic              cmd_stb_o,
  output spi_wb_pkg::data_t debug_o
);

  spi_wb_pkg::wb_req_t bus_req;
  spi_wb_pkg::wb_rsp_t bus_rsp;
  spi_wb_pkg::wb_req_t sys_req;
  spi_wb_pkg::wb_rsp_t sys_rsp;
  spi_wb_pkg::wb_req_t ram_req;
  spi_wb_pkg::wb_rsp_t ram_rsp;

  spi_wb_bridge u_bridge (
    .sys_clk   (sys_clk),
    .reset_i   (reset_i),
    .cs_n_i    (cs_n_i),
    .sclk_i    (sclk_i),
    .mosi_i    (mosi_i),
    .miso_o    (miso_o),
    .req_o     (bus_req),
    .rsp_i     (bus_rsp),
    .cmd_stb_o (cmd_stb_o)
  );

  // ****************************************
  // Bus decode and slaves
  // ****************************************
  wbs_decoder u_decoder (
    .sys_clk   (sys_clk),
    .reset_i   (reset_i),
    .req_i     (bus_req),
    .rsp_o     (bus_rsp),
    .sys_req_o (sys_req),
    .sys_rsp_i (sys_rsp),
    .ram_req_o (ram_req),
    .ram_rsp_i (ram_rsp)
  );

  sys_block u_sys_block (
    .sys_clk (sys_clk),
    .reset_i (reset_i),
    .req_i   (sys_req),
    .rsp_o   (sys_rsp),
    .debug_o (debug_o)
  );

  wb_scratch_ram u_ram (
    .sys_clk (sys_clk),
    .reset_i (reset_i),
    .req_i   (ram_req),
    .rsp_o   (ram_rsp)
  );

endmodule

// ==== hdl/sys_block.sv ====
`timescale 1ns/100ps

module sys_block (
  input  logic                sys_clk,
  input  logic                reset_i,
  input  spi_wb_pkg::wb_req_t req_i,
  output spi_wb_pkg::wb_rsp_t rsp_o,
  output spi_wb_pkg::data_t   debug_o
);

  logic              ack_q;
  logic              access;
  logic [7:0]        offset;
  spi_wb_pkg::data_t rd_q;
  spi_wb_pkg::data_t scratch_q;
  spi_wb_pkg::data_t debug_q;

  assign access = req_i.cyc & req_i.stb & ~ack_q;
  assign offset = req_i.adr[7:0];

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      ack_q     <= 1'b0;
      scratch_q <= '0;
      debug_q   <= '0;
    end else begin
      ack_q <= access;
      // Writes to ID, revision or unused offsets are simply dropped.
      if (access && req_i.we) begin
        if (offset == spi_wb_pkg::REG_SCRATCH) begin
          scratch_q <= req_i.dat;
        end
        if (offset == spi_wb_pkg::REG_DEBUG) begin
          debug_q <= req_i.dat;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (access) begin
      case (offset)
        spi_wb_pkg::REG_ID:      rd_q <= spi_wb_pkg::BOARD_ID;
        spi_wb_pkg::REG_REV:     rd_q <= {spi_wb_pkg::REV_MAJ, spi_wb_pkg::REV_MIN};
        spi_wb_pkg::REG_SCRATCH: rd_q <= scratch_q;
        spi_wb_pkg::REG_DEBUG:   rd_q <= debug_q;
        default:                 rd_q <= '0;
      endcase
    end
  end

  assign rsp_o   = '{ack: ack_q, err: 1'b0, dat: rd_q};
  assign debug_o = debug_q;

endmodule

// ==== hdl/wb_scratch_ram.sv ====
`timescale 1ns/100ps

module wb_scratch_ram (
  input  logic                sys_clk,
  input  logic                reset_i,
  input  spi_wb_pkg::wb_req_t req_i,
  output spi_wb_pkg::wb_rsp_t rsp_o
);

  spi_wb_pkg::data_t            mem [spi_wb_pkg::RAM_WORDS];
  spi_wb_pkg::data_t            rd_q;
  logic [spi_wb_pkg::RAM_AW-1:0] widx;
  logic                         ack_q;
  logic                         access;

  // The two low address bits select a byte within the word and are ignored.
  assign widx   = req_i.adr[spi_wb_pkg::RAM_AW+1:2];
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (access) begin
      if (req_i.we) begin
        mem[widx] <= req_i.dat;
      end
      rd_q <= mem[widx];
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rd_q};

endmodule

// ==== hdl/wbs_decoder.sv ====
`timescale 1ns/100ps

module wbs_decoder (
  input  logic                sys_clk,
  input  logic                reset_i,
  input  spi_wb_pkg::wb_req_t req_i,
  output spi_wb_pkg::wb_rsp_t rsp_o,
  output spi_wb_pkg::wb_req_t sys_req_o,
  input  spi_wb_pkg::wb_rsp_t sys_rsp_i,
  output spi_wb_pkg::wb_req_t ram_req_o,
  input  spi_wb_pkg::wb_rsp_t ram_rsp_i
);

  logic sys_hit;
  logic ram_hit;
  logic err_q;

  function automatic logic in_range(spi_wb_pkg::addr_t adr, spi_wb_pkg::addr_t base,
                                    spi_wb_pkg::addr_t high);
    return (adr >= base) && (adr <= high);
  endfunction

  assign sys_hit = in_range(req_i.adr, spi_wb_pkg::SYS_BASE, spi_wb_pkg::SYS_HIGH);
  assign ram_hit = in_range(req_i.adr, spi_wb_pkg::RAM_BASE, spi_wb_pkg::RAM_HIGH);

  // Only the addressed slave sees cyc and stb.
  always_comb begin
    sys_req_o     = req_i;
    sys_req_o.cyc = req_i.cyc & sys_hit;
    sys_req_o.stb = req_i.stb & sys_hit;
    ram_req_o     = req_i;
    ram_req_o.cyc = req_i.cyc & ram_hit;
    ram_req_o.stb = req_i.stb & ram_hit;
  end

  // An unmapped address is answered with a single error pulse.
  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_i.cyc & req_i.stb & ~sys_hit & ~ram_hit & ~err_q;
    end
  end

  always_comb begin
    if (sys_hit) begin
      rsp_o = sys_rsp_i;
    end else if (ram_hit) begin
      rsp_o = ram_rsp_i;
    end else begin
      rsp_o = '{ack: 1'b0, err: err_q, dat: '0};
    end
  end

endmodule

// ==== sources.f ====
hdl/spi_wb_pkg.sv
hdl/spi_wb_bridge.sv
hdl/wbs_decoder.sv
hdl/sys_block.sv
hdl/wb_scratch_ram.sv
hdl/spi_wb_top.sv
testbench/spi_wb_asserts.sv
testbench/tb_spi_wb.sv

// ==== testbench/spi_wb_asserts.sv ====
`timescale 1ns/100ps

module spi_wb_asserts (
  input logic                sys_clk,
  input logic                reset_i,
  input spi_wb_pkg::wb_req_t req_i,
  input spi_wb_pkg::wb_rsp_t rsp_i,
  input logic                cmd_stb_i
);

  int unsigned fail_count = 0;

  // The master keeps stb up until the addressed slave or the decoder answers.
  stb_held: assert property (@(posedge sys_clk) disable iff (reset_i)
    req_i.stb && !(rsp_i.ack || rsp_i.err) |=> req_i.stb)
    else begin
      $error("stb dropped before ack or err");
      fail_count++;
    end

  // A response belongs to a running cycle and is either ack or err.
  ack_err_excl: assert property (@(posedge sys_clk) disable iff (reset_i)
    rsp_i.ack || rsp_i.err |-> req_i.stb && !(rsp_i.ack && rsp_i.err))
    else begin
      $error("ack or err outside a bus cycle, or both high in the same cycle");
      fail_count++;
    end

  cmd_stb_pulse: assert property (@(posedge sys_clk) disable iff (reset_i)
    cmd_stb_i |=> !cmd_stb_i)
    else begin
      $error("cmd_stb_o high for more than one cycle");
      fail_count++;
    end

endmodule

bind spi_wb_bridge spi_wb_asserts u_asserts (
  .sys_clk   (sys_clk),
  .reset_i   (reset_i),
  .req_i     (req_o),
  .rsp_i     (rsp_i),
  .cmd_stb_i (cmd_stb_o)
);

// ==== testbench/tb_spi_wb.sv ====
`timescale 1ns/100ps

module tb_spi_wb;

  localparam int HALF_SCLK   = 4;
  localparam int FRAME_COUNT = 100;
  localparam int CYCLE_LIMIT = FRAME_COUNT * 120 * 8 + 1000;

  logic              sys_clk;
  logic              reset;
  logic              cs_n;
  logic              sclk;
  logic              mosi;
  logic              miso;
  logic              cmd_stb;
  spi_wb_pkg::data_t debug;

  // Shadow of the writable state inside the DUT.
  spi_wb_pkg::data_t scratch_sh = '0;
  spi_wb_pkg::data_t debug_sh = '0;
  spi_wb_pkg::data_t ram_sh [spi_wb_pkg::RAM_WORDS];

  spi_wb_pkg::addr_t rd_addr_q [$];
  spi_wb_pkg::data_t rd_data_q [$];
  spi_wb_pkg::addr_t chk_addr;
  spi_wb_pkg::data_t chk_got;
  spi_wb_pkg::data_t chk_exp;
  int cmp_errors = 0;
  int cmp_checks = 0;
  int chk_errors = 0;
  int chk_checks = 0;
  int test_start_err = 0;
  int pulses = 0;
  int frames_ok = 0;
  int cycles = 0;

  spi_wb_top dut (
    .sys_clk   (sys_clk),
    .reset_i   (reset),
    .cs_n_i    (cs_n),
    .sclk_i    (sclk),
    .mosi_i    (mosi),
    .miso_o    (miso),
    .cmd_stb_o (cmd_stb),
    .debug_o   (debug)
  );

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  // ****************************************
  // Reference model
  // ****************************************
  function automatic spi_wb_pkg::data_t expected_read(input spi_wb_pkg::addr_t adr);
    if (adr >= spi_wb_pkg::SYS_BASE && adr <= spi_wb_pkg::SYS_HIGH) begin
      case (adr[7:0])
        spi_wb_pkg::REG_ID:      return spi_wb_pkg::BOARD_ID;
        spi_wb_pkg::REG_REV:     return {spi_wb_pkg::REV_MAJ, spi_wb_pkg::REV_MIN};
        spi_wb_pkg::REG_SCRATCH: return scratch_sh;
        spi_wb_pkg::REG_DEBUG:   return debug_sh;
        default:                 return '0;
      endcase
    end else if (adr >= spi_wb_pkg::RAM_BASE && adr <= spi_wb_pkg::RAM_HIGH) begin
      return ram_sh[adr[7:2]];
    end
    return spi_wb_pkg::ERR_WORD;
  endfunction

  task automatic update_shadow(input spi_wb_pkg::addr_t adr, input spi_wb_pkg::data_t dat);
    if (adr >= spi_wb_pkg::SYS_BASE && adr <= spi_wb_pkg::SYS_HIGH) begin
      if (adr[7:0] == spi_wb_pkg::REG_SCRATCH) begin
        scratch_sh = dat;
      end
      if (adr[7:0] == spi_wb_pkg::REG_DEBUG) begin
        debug_sh = dat;
      end
    end else if (adr >= spi_wb_pkg::RAM_BASE && adr <= spi_wb_pkg::RAM_HIGH) begin
      ram_sh[adr[7:2]] = dat;
    end
  endtask

  function automatic int total_errors();
    return cmp_errors + chk_errors + int'(dut.u_bridge.u_asserts.fail_count);
  endfunction

  // ****************************************
  // SPI master
  // ****************************************
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge sys_clk);
    #1;
  endtask

  // In mode 0 mosi changes with the falling sclk and miso is taken at the rising sclk.
  task automatic run_frame(input logic [63:0] tx, input int nbits,
                           output spi_wb_pkg::data_t rx);
    rx = '0;
    cs_n = 1'b0;
    wait_cycles(HALF_SCLK);
    for (int i = 0; i < nbits; i++) begin
      mosi = tx[63 - i];
      wait_cycles(HALF_SCLK);
      rx = {rx[30:0], miso};
      sclk = 1'b1;
      wait_cycles(HALF_SCLK);
      sclk = 1'b0;
    end
    wait_cycles(HALF_SCLK);
    cs_n = 1'b1;
    mosi = 1'b0;
    wait_cycles(2 * HALF_SCLK);
  endtask

  task automatic write_word(input spi_wb_pkg::addr_t adr, input spi_wb_pkg::data_t dat);
    spi_wb_pkg::data_t rx;
    run_frame({spi_wb_pkg::OP_WRITE, adr, dat, 8'h00}, 56, rx);
    update_shadow(adr, dat);
    frames_ok++;
  endtask

  task automatic read_word(input spi_wb_pkg::addr_t adr);
    spi_wb_pkg::data_t rx;
    run_frame({spi_wb_pkg::OP_READ, adr, 40'h0}, 64, rx);
    rd_addr_q.push_back(adr);
    rd_data_q.push_back(rx);
    frames_ok++;
  endtask

  // ****************************************
  // Checking and reporting
  // ****************************************
  always @(posedge sys_clk) begin
    while (rd_addr_q.size() > 0) begin
      chk_addr = rd_addr_q.pop_front();
      chk_got  = rd_data_q.pop_front();
      chk_exp  = expected_read(chk_addr);
      cmp_checks++;
      if (chk_got !== chk_exp) begin
        cmp_errors++;
        $display("Mismatch at %0t ns: miso_o read of 0x%04h got 0x%08h, expected 0x%08h",
                 $time, chk_addr, chk_got, chk_exp);
      end
    end
  end

  always @(posedge sys_clk) begin
    if (!reset && cmd_stb) begin
      pulses++;
    end
  end

  task automatic check_debug();
    chk_checks++;
    if (debug !== debug_sh) begin
      chk_errors++;
      $display("Mismatch at %0t ns: debug_o got 0x%08h, expected 0x%08h",
               $time, debug, debug_sh);
    end
  endtask

  task automatic check_pulses();
    chk_checks++;
    if (pulses != frames_ok) begin
      chk_errors++;
      $display("Mismatch at %0t ns: cmd_stb_o pulse count got %0d, expected %0d",
               $time, pulses, frames_ok);
    end
  endtask

  task automatic finish_test(input int num, input string name);
    wait_cycles(2);
    check_pulses();
    if (total_errors() == test_start_err) begin
      $display("[test %0d] %s: ok", num, name);
    end else begin
      $display("[test %0d] %s: %0d error(s)", num, name, total_errors() - test_start_err);
    end
    test_start_err = total_errors();
  endtask

  initial begin : watchdog
    while (cycles < CYCLE_LIMIT) begin
      @(posedge sys_clk);
      cycles++;
    end
    $display("Timeout: the test sequence did not end within %0d cycles", CYCLE_LIMIT);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    spi_wb_pkg::data_t                rx;
    spi_wb_pkg::addr_t                adr;
    int                               idx;
    int                               first_idx;
    logic [spi_wb_pkg::RAM_WORDS-1:0] used;
    reset = 1'b1;
    cs_n  = 1'b1;
    sclk  = 1'b0;
    mosi  = 1'b0;
    void'($urandom(63508));
    wait_cycles(5);
    reset = 1'b0;
    wait_cycles(2);

    check_debug();
    read_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_ID);
    read_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_REV);
    finish_test(1, "reset values");

    write_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_SCRATCH, $urandom());
    read_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_SCRATCH);
    write_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_DEBUG, $urandom());
    check_debug();
    read_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_DEBUG);
    write_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_ID, 32'hFFFF_FFFF);
    read_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_ID);
    write_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_REV, 32'hFFFF_FFFF);
    read_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_REV);
    finish_test(2, "system registers");

    used = '0;
    first_idx = 0;
    for (int i = 0; i < 40; i++) begin
      idx = $urandom_range(spi_wb_pkg::RAM_WORDS - 1);
      if (i == 0) begin
        first_idx = idx;
      end
      used[idx] = 1'b1;
      write_word(spi_wb_pkg::RAM_BASE + 16'(idx * 4), $urandom());
    end
    for (int i = 0; i < spi_wb_pkg::RAM_WORDS; i++) begin
      if (used[i]) begin
        read_word(spi_wb_pkg::RAM_BASE + 16'(i * 4));
      end
    end
    finish_test(3, "scratch RAM");

    // The unmapped writes share their low address bits with the scratch register
    // and with a written RAM word, so a write that leaks through shows up below.
    read_word(16'h2000);
    write_word(16'h2000 + spi_wb_pkg::REG_SCRATCH, $urandom());
    write_word(16'h2000 + 16'(first_idx * 4), $urandom());
    read_word(16'h2000);
    read_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_SCRATCH);
    read_word(spi_wb_pkg::RAM_BASE + 16'(first_idx * 4));
    check_debug();
    finish_test(4, "unmapped address");

    // Neither an unknown opcode nor an aborted write may start a bus cycle.
    adr = spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_DEBUG;
    run_frame({8'h55, adr, 32'hFFFF_FFFF, 8'h00}, 56, rx);
    run_frame({spi_wb_pkg::OP_WRITE, adr, 32'hFFFF_FFFF, 8'h00}, 40, rx);
    check_pulses();
    check_debug();
    read_word(adr);
    read_word(spi_wb_pkg::SYS_BASE + spi_wb_pkg::REG_SCRATCH);
    finish_test(5, "frame counting");

    $display("Checks: %0d, errors: %0d", cmp_checks + chk_checks, total_errors());
    if (total_errors() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
